//--- design/besm_pkg.sv
// Shared widths, encodings and bus structs. Enum codes follow the original microcode fields
package besm_pkg;

    // --------------------
    // Widths and sizes
    localparam int WORD_W     = 32;                 // Y bus word
    localparam int PAGE_BITS  = 10;                 // Page number width
    localparam int PAGE_COUNT = 1 << PAGE_BITS;     // 1024 pages
    localparam int MAP_W      = 20;                 // Page map entry
    localparam int ADDR_W     = 20;                 // External address
    localparam int PG_LSB     = ADDR_W - PAGE_BITS; // Page field starts at bit 10
    localparam logic [PAGE_BITS-1:0] PAGE_LAST = PAGE_BITS'(PAGE_COUNT - 1);

    // Mode register bit positions
    localparam int RR_NORMB  = 0;   // Normalization block
    localparam int RR_RNDB   = 1;   // Rounding block
    localparam int RR_GRP    = 2;   // Group field, 3 bits one-hot
    localparam int RR_OVRIB  = 5;   // Overflow interrupt block
    localparam int RR_BNB    = 10;  // Range check block
    localparam int RR_OVRFTB = 11;  // Stash overflow block
    localparam int RR_DRG    = 12;  // Dispatcher mode
    localparam int RR_NOINTR = 17;  // Interrupt mask
    localparam int RR_CEMLRG = 19;  // Reserved emulation bit
    localparam int RR_CB     = 27;  // Address changed by reg 16
    localparam int RR_RCB    = 28;  // Right command flag
    localparam int RR_JUMP   = 29;  // Jump command flag

    // --------------------
    // Microcommand field encodings
    typedef enum logic [3:0] {
        YD_NONE = 4'd0, YD_CNT = 4'd3, YD_PHYSPG = 4'd4, YD_ARBOPC = 4'd5, YD_ADRREG = 4'd8
    } y_dst_e;

    typedef enum logic [2:0] {YV_NONE = 3'd0, YV_PSMEM = 3'd4} y_dev_e;

    typedef enum logic [2:0] {
        DV_NONE = 3'd0, DV_ACCESS = 3'd1, DV_REPRIO = 3'd2, DV_CLRCB = 3'd3
    } d_dev_e;

    typedef enum logic [4:0] {
        FF_NONE = 5'd0,  LOGGRP = 5'd1,  MULGRP = 5'd2,  ADDGRP = 5'd3,  SETC = 5'd5,
        CLRRCB = 5'd6,   SETRCB = 5'd7,  CLRJMP = 5'd8,  SETJMP = 5'd9,  SETEI = 5'd10,
        CLREI = 5'd11,   CLRTR0 = 5'd12, SETTR0 = 5'd13, CLRTR1 = 5'd14, SETTR1 = 5'd15,
        CLRTKK = 5'd18,  SETTKK = 5'd19, SETNR = 5'd20,  STRTLD = 5'd21, SETER = 5'd22,
        CHTKK = 5'd23
    } flag_op_e;

    typedef enum logic [4:0] {
        C_YES = 5'd0,     C_NORMB = 5'd1,  C_RNDB = 5'd2,  C_OVRIB = 5'd3,
        C_BNB = 5'd4,     C_OVRFTB = 5'd5, C_DRG = 5'd6,   C_EMLRG = 5'd7,
        C_RCB = 5'd8,     C_CB = 5'd9,     C_CEMLRG = 5'd10, C_TR1 = 5'd12,
        C_TKK = 5'd15,    C_FULMEM = 5'd20, C_ARBRDY = 5'd21, C_TR0 = 5'd22
    } cond_e;

    typedef enum logic [3:0] {ARB_NONE = 4'd0, ARB_READ = 4'd1, ARB_WRITE = 4'd2} arb_op_e;

    // --------------------
    // Structs
    typedef struct packed {
        y_dst_e   ydst;     // Y destination
        y_dev_e   ydev;     // Y device
        logic     wry;      // Y device write
        d_dev_e   ddev;     // D device
        logic     wrd;      // D device write
        logic     iomp;     // Low selects flag decoder
        flag_op_e ffcnt;    // Flag trigger code
        arb_op_e  arbi;     // Arbiter opcode
        cond_e    cond_sel; // Condition select
        logic     icc;      // Condition invert
        logic     ise;      // Copy TKK into RCB
    } micro_op_t;

    typedef struct packed {
        logic [MAP_W-1:0] map;  // Map entry at ureg page
        logic             inv;  // Page invalid
        logic             ro;   // Page read only
        logic             reprio; // Reprioritize request
    } page_rd_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [WORD_W-1:0] dat;
    } wb_m2s_t;

    typedef struct packed {
        logic              ack;
        logic [WORD_W-1:0] dat;
    } wb_s2m_t;

endpackage

//--- design/mode_cond_unit.sv
// Flag triggers act only with iomp low and override a same-cycle YD_CNT load; o_cond is combinational
`timescale 1ns/1ps

module mode_cond_unit (
    input  logic                        clk,          // System clock
    input  logic                        reset,        // Sync reset, active high
    input  besm_pkg::micro_op_t         i_uop,        // Decoded microcommand
    input  logic [besm_pkg::WORD_W-1:0] i_y,          // Y bus word
    input  logic                        i_arb_rdy,    // Arbiter done pulse
    input  logic                        i_fill_busy,  // Reprio fill running
    output logic [besm_pkg::WORD_W-1:0] o_rr,         // Mode register
    output logic                        o_cond,       // Tested condition
    output logic                        o_fill_start  // STRTLD pulse to page table
);
    import besm_pkg::*;

    logic [WORD_W-1:0] rr;          // Mode register RR
    logic              tr0;         // Microprogram trace flag 0
    logic              tr1;         // Microprogram trace flag 1
    logic              tkk;         // Standardizer right command
    logic              emul_mode;   // Emulation mode
    logic              ff_en;       // Flag decoder enabled
    logic              cond_raw;    // Selected condition before invert

    assign ff_en = ~i_uop.iomp;     // iomp high selects clock/timer decoder

    // --------------------
    // Mode register and flags
    always_ff @(posedge clk) begin
        if (reset) begin
            rr        <= '0;
            tr0       <= 1'b0;
            tr1       <= 1'b0;
            tkk       <= 1'b0;
            emul_mode <= 1'b0;
        end else begin
            if (i_uop.ydst == YD_CNT)
                rr <= i_y;                          // Whole word load
            if (ff_en) begin
                case (i_uop.ffcnt)
                    LOGGRP: rr[RR_GRP +: 3] <= 3'b001;  // Logic group
                    MULGRP: rr[RR_GRP +: 3] <= 3'b010;  // Multiply group
                    ADDGRP: rr[RR_GRP +: 3] <= 3'b100;  // Add group
                    CLRJMP: rr[RR_JUMP]     <= 1'b0;
                    SETJMP: rr[RR_JUMP]     <= 1'b1;
                    SETEI:  rr[RR_NOINTR]   <= 1'b0;    // Enable means mask off
                    CLREI:  rr[RR_NOINTR]   <= 1'b1;
                    CLRTR0: tr0             <= 1'b0;
                    SETTR0: tr0             <= 1'b1;
                    CLRTR1: tr1             <= 1'b0;
                    SETTR1: tr1             <= 1'b1;
                    CLRTKK: tkk             <= 1'b0;
                    SETTKK: tkk             <= 1'b1;
                    SETNR:  emul_mode       <= 1'b0;    // Native mode
                    SETER:  emul_mode       <= 1'b1;    // Emulation mode
                    CHTKK:  tkk             <= ~tkk;    // Toggle
                    default: ;                          // CB, RCB and STRTLD below
                endcase
            end

            // CB has its own clear path from the D device decoder
            if (i_uop.ddev == DV_CLRCB)
                rr[RR_CB] <= 1'b0;
            else if (ff_en && i_uop.ffcnt == SETC)
                rr[RR_CB] <= 1'b1;

            // RCB takes TKK on ise, else the trigger codes
            if (i_uop.ise)
                rr[RR_RCB] <= tkk;
            else if (ff_en && i_uop.ffcnt == CLRRCB)
                rr[RR_RCB] <= 1'b0;
            else if (ff_en && i_uop.ffcnt == SETRCB)
                rr[RR_RCB] <= 1'b1;
        end
    end

    assign o_rr         = rr;
    assign o_fill_start = ff_en && (i_uop.ffcnt == STRTLD);  // Fill begins next edge

    // --------------------
    // Condition multiplexer
    always_comb begin
        case (i_uop.cond_sel)
            C_YES:    cond_raw = 1'b1;
            C_NORMB:  cond_raw = rr[RR_NORMB];
            C_RNDB:   cond_raw = rr[RR_RNDB];
            C_OVRIB:  cond_raw = rr[RR_OVRIB];
            C_BNB:    cond_raw = rr[RR_BNB];
            C_OVRFTB: cond_raw = rr[RR_OVRFTB];
            C_DRG:    cond_raw = rr[RR_DRG];
            C_EMLRG:  cond_raw = emul_mode;
            C_RCB:    cond_raw = rr[RR_RCB];
            C_CB:     cond_raw = rr[RR_CB];
            C_CEMLRG: cond_raw = rr[RR_CEMLRG];
            C_TR1:    cond_raw = tr1;
            C_TKK:    cond_raw = tkk;
            C_FULMEM: cond_raw = ~i_fill_busy;      // Reprio memory all ones
            C_ARBRDY: cond_raw = i_arb_rdy;
            C_TR0:    cond_raw = tr0;
            default:  cond_raw = 1'b1;              // Unused codes test true
        endcase
    end

    assign o_cond = cond_raw ^ i_uop.icc;

    // Group field must come out one-hot whatever else hits RR that cycle
    a_grp_onehot: assert property (@(posedge clk) disable iff (reset)
        (ff_en && (i_uop.ffcnt inside {LOGGRP, MULGRP, ADDGRP}))
        |=> $onehot(rr[RR_GRP +: 3]));

endmodule

//--- design/page_table.sv
// Memories have no reset; fill ignores a new start while busy and beats command writes to reprio
`timescale 1ns/1ps

module page_table (
    input  logic                        clk,          // System clock
    input  logic                        reset,        // Sync reset, active high
    input  besm_pkg::micro_op_t         i_uop,        // Decoded microcommand
    input  logic [besm_pkg::WORD_W-1:0] i_y,          // Y bus word
    input  logic                        i_fill_start, // STRTLD from mode unit
    output logic [besm_pkg::WORD_W-1:0] o_ureg,       // Effective address register
    output besm_pkg::page_rd_t          o_page_rd,    // Registered page readback
    output logic                        o_fill_busy   // Fill engine running
);
    import besm_pkg::*;

    // --------------------
    // Registers and memories
    logic [WORD_W-1:0]    ureg;                     // Effective address
    logic [PAGE_BITS-1:0] pg_index;                 // Physical page register
    logic [MAP_W-1:0]     pg_map    [PAGE_COUNT];   // Page map
    logic                 pg_inv    [PAGE_COUNT];   // Access blocked
    logic                 pg_ro     [PAGE_COUNT];   // Write blocked
    logic                 pg_reprio [PAGE_COUNT];   // Reprioritize bits

    logic                 fill_busy;                // Fill with ones active
    logic [PAGE_BITS-1:0] fill_cnt;                 // Next entry to fill
    logic [PAGE_BITS-1:0] map_idx;                  // Page of ureg
    logic                 map_we;
    logic                 acc_we;
    logic                 rep_we;
    page_rd_t             page_rd;

    assign map_idx = ureg[PG_LSB +: PAGE_BITS];     // Bits 19:10
    assign map_we  = i_uop.wry && (i_uop.ydev == YV_PSMEM);
    assign acc_we  = i_uop.wrd && (i_uop.ddev == DV_ACCESS);
    assign rep_we  = i_uop.wrd && (i_uop.ddev == DV_REPRIO);

    // Address and page registers
    always_ff @(posedge clk) begin
        if (reset) begin
            ureg     <= '0;
            pg_index <= '0;
        end else begin
            if (i_uop.ydst == YD_ADRREG)
                ureg <= i_y;
            if (i_uop.ydst == YD_PHYSPG)
                pg_index <= i_y[PG_LSB +: PAGE_BITS];
        end
    end

    // --------------------
    // Fill engine
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_busy <= 1'b0;
            fill_cnt  <= '0;
        end else if (fill_busy) begin
            if (fill_cnt == PAGE_LAST)
                fill_busy <= 1'b0;                  // Last entry written now
            else
                fill_cnt <= fill_cnt + 1'b1;
        end else if (i_fill_start) begin
            fill_busy <= 1'b1;
            fill_cnt  <= pg_index;                  // Start at current page
        end
    end

    // Map and access writes
    always_ff @(posedge clk) begin
        if (map_we)
            pg_map[map_idx] <= i_y[MAP_W-1:0];
        if (acc_we) begin
            pg_inv[pg_index] <= i_y[1];
            pg_ro[pg_index]  <= i_y[2];
        end
    end

    // Reprio memory, fill wins over the command port
    always_ff @(posedge clk) begin
        if (fill_busy)
            pg_reprio[fill_cnt] <= 1'b1;
        else if (rep_we)
            pg_reprio[pg_index] <= i_y[0];          // Lost while fill runs
    end

    // --------------------
    // Readback, one cycle behind the write
    always_ff @(posedge clk) begin
        page_rd.map    <= pg_map[map_idx];
        page_rd.inv    <= pg_inv[pg_index];
        page_rd.ro     <= pg_ro[pg_index];
        page_rd.reprio <= pg_reprio[pg_index];
    end

    assign o_ureg      = ureg;
    assign o_page_rd   = page_rd;
    assign o_fill_busy = fill_busy;

    // Counter stops at the last page instead of wrapping
    a_fill_end: assert property (@(posedge clk) disable iff (reset)
        (fill_busy && fill_cnt == PAGE_LAST) |=> !fill_busy);

endmodule

//--- design/ext_bus_arbiter.sv
// Single requester Wishbone classic master; opcodes other than READ/WRITE and those during a cycle are dropped
`timescale 1ns/1ps

module ext_bus_arbiter (
    input  logic                        clk,        // System clock
    input  logic                        reset,      // Sync reset, active high
    input  besm_pkg::micro_op_t         i_uop,      // Decoded microcommand
    input  logic [besm_pkg::WORD_W-1:0] i_y,        // Y bus word, write data
    input  logic [besm_pkg::WORD_W-1:0] i_ureg,     // Effective address
    input  besm_pkg::wb_s2m_t           i_wb,       // Slave response
    output besm_pkg::wb_m2s_t           o_wb,       // Master request
    output logic [besm_pkg::WORD_W-1:0] o_rd_data,  // Latched read data
    output logic                        o_arb_rdy   // One cycle after ack
);
    import besm_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_WAIT, S_DONE} arb_state_e;

    arb_state_e        state;
    arb_op_e           req;         // Request register
    arb_op_e           new_op;      // Opcode offered this cycle
    logic              accept;
    logic [ADDR_W-1:0] adr_q;       // Held address
    logic [WORD_W-1:0] dat_q;       // Held write data
    logic [WORD_W-1:0] rd_data;

    // --------------------
    // Opcode source, Y bus first
    always_comb begin
        if (i_uop.ydst == YD_ARBOPC)
            new_op = arb_op_e'(i_y[3:0]);
        else
            new_op = i_uop.arbi;
    end

    assign accept = (state != S_WAIT) && (new_op == ARB_READ || new_op == ARB_WRITE);

    // Cycle FSM
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            req   <= ARB_NONE;
        end else begin
            case (state)
                S_WAIT: begin
                    if (i_wb.ack) begin
                        state <= S_DONE;            // Ready next cycle
                        req   <= ARB_NONE;
                    end
                end
                default: begin                      // Idle or done accept new work
                    if (accept) begin
                        state <= S_WAIT;
                        req   <= new_op;
                    end else begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // Address, write data and read data
    always_ff @(posedge clk) begin
        if (accept) begin
            adr_q <= i_ureg[ADDR_W-1:0];
            dat_q <= i_y;
        end
        if (state == S_WAIT && i_wb.ack && req == ARB_READ)
            rd_data <= i_wb.dat;
    end

    // --------------------
    // Bus outputs
    assign o_wb.cyc  = (state == S_WAIT);
    assign o_wb.stb  = (state == S_WAIT);
    assign o_wb.we   = (req == ARB_WRITE);
    assign o_wb.adr  = adr_q;
    assign o_wb.dat  = dat_q;
    assign o_rd_data = rd_data;
    assign o_arb_rdy = (state == S_DONE);

    a_stb_cyc: assert property (@(posedge clk) disable iff (reset)
        o_wb.stb |-> o_wb.cyc);

    // Request held steady under back-pressure
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        (o_wb.cyc && !i_wb.ack)
        |=> ($stable(o_wb.adr) && $stable(o_wb.we) && $stable(o_wb.dat)));

endmodule

//--- design/besm_ctrl_top.sv
// Wires the mode unit, page table and bus arbiter; all units share the microcommand and Y word
`timescale 1ns/1ps

module besm_ctrl_top (
    input  logic                        clk,        // System clock
    input  logic                        reset,      // Sync reset, active high
    input  besm_pkg::micro_op_t         i_uop,      // One microcommand per cycle
    input  logic [besm_pkg::WORD_W-1:0] i_y,        // Y bus word
    input  besm_pkg::wb_s2m_t           i_wb,       // Wishbone slave response
    output logic [besm_pkg::WORD_W-1:0] o_rr,       // Mode register
    output logic                        o_cond,     // Tested condition
    output besm_pkg::page_rd_t          o_page_rd,  // Page readback
    output besm_pkg::wb_m2s_t           o_wb,       // Wishbone master request
    output logic [besm_pkg::WORD_W-1:0] o_rd_data,  // Bus read data
    output logic                        o_arb_rdy   // Bus cycle done
);
    import besm_pkg::*;

    logic [WORD_W-1:0] ureg;        // Bus address source
    logic              fill_busy;   // For FULMEM
    logic              fill_start;  // STRTLD pulse

    // --------------------
    mode_cond_unit u_mode (
        .clk          (clk),
        .reset        (reset),
        .i_uop        (i_uop),
        .i_y          (i_y),
        .i_arb_rdy    (o_arb_rdy),
        .i_fill_busy  (fill_busy),
        .o_rr         (o_rr),
        .o_cond       (o_cond),
        .o_fill_start (fill_start)
    );

    page_table u_page (
        .clk          (clk),
        .reset        (reset),
        .i_uop        (i_uop),
        .i_y          (i_y),
        .i_fill_start (fill_start),
        .o_ureg       (ureg),
        .o_page_rd    (o_page_rd),
        .o_fill_busy  (fill_busy)
    );

    ext_bus_arbiter u_arb (
        .clk       (clk),
        .reset     (reset),
        .i_uop     (i_uop),
        .i_y       (i_y),
        .i_ureg    (ureg),
        .i_wb      (i_wb),
        .o_wb      (o_wb),
        .o_rd_data (o_rd_data),
        .o_arb_rdy (o_arb_rdy)
    );

endmodule

//--- tb/tb_top.sv
// Checks are off during reset; page readback fields are compared only after the test wrote them
`timescale 1ns/1ps

module tb_top;
    import besm_pkg::*;

    logic              clk = 1'b0;
    logic              reset;
    micro_op_t         uop;
    logic [WORD_W-1:0] y;
    wb_s2m_t           wb_s = '0;           // Slave response
    logic [WORD_W-1:0] o_rr;
    logic              o_cond;
    page_rd_t          o_page_rd;
    wb_m2s_t           o_wb;
    logic [WORD_W-1:0] o_rd_data;
    logic              o_arb_rdy;

    besm_ctrl_top DUT (
        .clk (clk), .reset (reset), .i_uop (uop), .i_y (y), .i_wb (wb_s),
        .o_rr (o_rr), .o_cond (o_cond), .o_page_rd (o_page_rd), .o_wb (o_wb),
        .o_rd_data (o_rd_data), .o_arb_rdy (o_arb_rdy)
    );

    always #4 clk = ~clk;                   // 8 ns period

    logic [31:0] rng = 32'd47;              // xorshift state
    flag_op_e trig_list [19] = '{LOGGRP, MULGRP, ADDGRP, SETC, CLRRCB, SETRCB, CLRJMP,
        SETJMP, SETEI, CLREI, CLRTR0, SETTR0, CLRTR1, SETTR1, CLRTKK, SETTKK, SETNR,
        SETER, CHTKK};

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    task automatic fail_value(string sig, logic [31:0] got, logic [31:0] exp);
        $display("[FAIL] t=%0t %s got=%h expected=%h", $time, sig, got, exp);
        $display("Test failures found");
        $fatal(1, "value mismatch");
    endtask

    task automatic fail_timeout(string what);
        $display("Timeout at t=%0t: %s", $time, what);
        $display("Test failures found");
        $fatal(1, "wait timed out");
    endtask

    // --------------------
    // Wishbone slave, random ack delay 0 to 5
    int unsigned ack_wait = 0;
    int unsigned ack_delay = 0;
    always @(negedge clk) begin
        if (reset || !(o_wb.cyc && o_wb.stb) || wb_s.ack) begin
            wb_s.ack <= 1'b0;               // One ack per cycle
            ack_wait <= 0;
        end else if (ack_wait >= ack_delay) begin
            wb_s.ack  <= 1'b1;
            wb_s.dat  <= next_rand();       // Read data
            ack_delay <= next_rand() % 6;
        end else begin
            ack_wait <= ack_wait + 1;
        end
    end

    // --------------------
    // Reference model
    logic [WORD_W-1:0] m_rr;
    logic              m_tr0, m_tr1, m_tkk, m_emul, m_cond;
    logic [WORD_W-1:0] m_ureg;
    logic [9:0]        m_pg, m_fcnt;
    logic              m_fill;
    logic [MAP_W-1:0]  m_map [PAGE_COUNT];
    logic              m_inv [PAGE_COUNT];
    logic              m_ro  [PAGE_COUNT];
    logic              m_rep [PAGE_COUNT];
    bit                v_map [PAGE_COUNT];  // Entry written by test
    bit                v_acc [PAGE_COUNT];
    bit                v_rep [PAGE_COUNT];
    page_rd_t          e_rd;                // Expected readback
    logic              e_vmap, e_vacc, e_vrep;
    logic              m_pend, m_we, m_rdy, m_rdat_vld;
    logic [ADDR_W-1:0] m_adr;
    logic [WORD_W-1:0] m_dat, m_rdat;
    arb_op_e           opc;

    always @(posedge clk) begin
        if (reset) begin
            m_rr   <= '0;
            m_tr0  <= 1'b0;
            m_tr1  <= 1'b0;
            m_tkk  <= 1'b0;
            m_emul <= 1'b0;
        end else begin
            if (uop.ydst == YD_CNT)
                m_rr <= y;
            if (!uop.iomp) begin
                case (uop.ffcnt)
                    LOGGRP: m_rr[RR_GRP +: 3] <= 3'b001;
                    MULGRP: m_rr[RR_GRP +: 3] <= 3'b010;
                    ADDGRP: m_rr[RR_GRP +: 3] <= 3'b100;
                    SETC:   m_rr[RR_CB] <= 1'b1;
                    CLRRCB: m_rr[RR_RCB] <= 1'b0;
                    SETRCB: m_rr[RR_RCB] <= 1'b1;
                    CLRJMP: m_rr[RR_JUMP] <= 1'b0;
                    SETJMP: m_rr[RR_JUMP] <= 1'b1;
                    SETEI:  m_rr[RR_NOINTR] <= 1'b0;
                    CLREI:  m_rr[RR_NOINTR] <= 1'b1;
                    CLRTR0: m_tr0 <= 1'b0;
                    SETTR0: m_tr0 <= 1'b1;
                    CLRTR1: m_tr1 <= 1'b0;
                    SETTR1: m_tr1 <= 1'b1;
                    CLRTKK: m_tkk <= 1'b0;
                    SETTKK: m_tkk <= 1'b1;
                    CHTKK:  m_tkk <= ~m_tkk;
                    SETNR:  m_emul <= 1'b0;
                    SETER:  m_emul <= 1'b1;
                    default: ;
                endcase
            end
            if (uop.ddev == DV_CLRCB)
                m_rr[RR_CB] <= 1'b0;         // Clear path wins over SETC
            if (uop.ise)
                m_rr[RR_RCB] <= m_tkk;
        end
    end

    always_comb begin
        case (uop.cond_sel)
            C_NORMB:  m_cond = m_rr[RR_NORMB];
            C_RNDB:   m_cond = m_rr[RR_RNDB];
            C_OVRIB:  m_cond = m_rr[RR_OVRIB];
            C_BNB:    m_cond = m_rr[RR_BNB];
            C_OVRFTB: m_cond = m_rr[RR_OVRFTB];
            C_DRG:    m_cond = m_rr[RR_DRG];
            C_EMLRG:  m_cond = m_emul;
            C_RCB:    m_cond = m_rr[RR_RCB];
            C_CB:     m_cond = m_rr[RR_CB];
            C_CEMLRG: m_cond = m_rr[RR_CEMLRG];
            C_TR1:    m_cond = m_tr1;
            C_TKK:    m_cond = m_tkk;
            C_FULMEM: m_cond = ~m_fill;
            C_ARBRDY: m_cond = m_rdy;
            C_TR0:    m_cond = m_tr0;
            default:  m_cond = 1'b1;        // C_YES and unused codes
        endcase
        m_cond = m_cond ^ uop.icc;
    end

    always @(posedge clk) begin
        if (reset) begin
            m_ureg <= '0;
            m_pg   <= '0;
            m_fill <= 1'b0;
            m_fcnt <= '0;
        end else begin
            if (uop.ydst == YD_ADRREG)
                m_ureg <= y;
            if (uop.ydst == YD_PHYSPG)
                m_pg <= y[19:10];
            if (m_fill) begin
                m_rep[m_fcnt] <= 1'b1;      // One entry per cycle
                v_rep[m_fcnt] <= 1'b1;
                if (m_fcnt == 10'd1023)
                    m_fill <= 1'b0;
                else
                    m_fcnt <= m_fcnt + 10'd1;
            end else if (!uop.iomp && uop.ffcnt == STRTLD) begin
                m_fill <= 1'b1;
                m_fcnt <= m_pg;
            end else if (uop.wrd && uop.ddev == DV_REPRIO) begin
                m_rep[m_pg] <= y[0];        // Dropped while filling
                v_rep[m_pg] <= 1'b1;
            end
            if (uop.wry && uop.ydev == YV_PSMEM) begin
                m_map[m_ureg[19:10]] <= y[MAP_W-1:0];
                v_map[m_ureg[19:10]] <= 1'b1;
            end
            if (uop.wrd && uop.ddev == DV_ACCESS) begin
                m_inv[m_pg] <= y[1];
                m_ro[m_pg]  <= y[2];
                v_acc[m_pg] <= 1'b1;
            end
        end
        e_rd   <= '{map: m_map[m_ureg[19:10]], inv: m_inv[m_pg], ro: m_ro[m_pg],
                    reprio: m_rep[m_pg]};
        e_vmap <= v_map[m_ureg[19:10]];
        e_vacc <= v_acc[m_pg];
        e_vrep <= v_rep[m_pg];
    end

    assign opc = (uop.ydst == YD_ARBOPC) ? arb_op_e'(y[3:0]) : uop.arbi;

    always @(posedge clk) begin
        if (reset) begin
            m_pend     <= 1'b0;
            m_rdy      <= 1'b0;
            m_rdat_vld <= 1'b0;
        end else begin
            m_rdy <= m_pend && wb_s.ack;
            if (m_pend) begin
                if (wb_s.ack) begin
                    m_pend <= 1'b0;
                    if (!m_we) begin
                        m_rdat     <= wb_s.dat;
                        m_rdat_vld <= 1'b1;
                    end
                end
            end else if (opc == ARB_READ || opc == ARB_WRITE) begin
                m_pend <= 1'b1;
                m_we   <= (opc == ARB_WRITE);
                m_adr  <= m_ureg[ADDR_W-1:0];
                m_dat  <= y;                 // Write data from this edge
            end
        end
    end

    // --------------------
    // Checks
    a_rr: assert property (@(posedge clk) disable iff (reset) o_rr == m_rr)
        else fail_value("o_rr", $sampled(o_rr), $sampled(m_rr));
    a_cond: assert property (@(posedge clk) disable iff (reset) o_cond == m_cond)
        else fail_value("o_cond", $sampled(o_cond), $sampled(m_cond));
    a_cyc: assert property (@(posedge clk) disable iff (reset)
        o_wb.cyc == m_pend && o_wb.stb == m_pend)
        else fail_value("o_wb.cyc/stb", {$sampled(o_wb.cyc), $sampled(o_wb.stb)},
                        {$sampled(m_pend), $sampled(m_pend)});
    a_adr: assert property (@(posedge clk) disable iff (reset)
        m_pend |-> o_wb.adr == m_adr && o_wb.we == m_we)
        else fail_value("o_wb.adr/we", {$sampled(o_wb.we), $sampled(o_wb.adr)},
                        {$sampled(m_we), $sampled(m_adr)});
    a_dat: assert property (@(posedge clk) disable iff (reset)
        m_pend && m_we |-> o_wb.dat == m_dat)
        else fail_value("o_wb.dat", $sampled(o_wb.dat), $sampled(m_dat));
    a_rdy: assert property (@(posedge clk) disable iff (reset) o_arb_rdy == m_rdy)
        else fail_value("o_arb_rdy", $sampled(o_arb_rdy), $sampled(m_rdy));
    a_rdata: assert property (@(posedge clk) disable iff (reset)
        m_rdat_vld |-> o_rd_data == m_rdat)
        else fail_value("o_rd_data", $sampled(o_rd_data), $sampled(m_rdat));
    a_map: assert property (@(posedge clk) disable iff (reset)
        e_vmap |-> o_page_rd.map == e_rd.map)
        else fail_value("o_page_rd.map", $sampled(o_page_rd.map), $sampled(e_rd.map));
    a_acc: assert property (@(posedge clk) disable iff (reset)
        e_vacc |-> {o_page_rd.inv, o_page_rd.ro} == {e_rd.inv, e_rd.ro})
        else fail_value("o_page_rd.inv/ro", {$sampled(o_page_rd.inv), $sampled(o_page_rd.ro)},
                        {$sampled(e_rd.inv), $sampled(e_rd.ro)});
    a_rep: assert property (@(posedge clk) disable iff (reset)
        e_vrep |-> o_page_rd.reprio == e_rd.reprio)
        else fail_value("o_page_rd.reprio", $sampled(o_page_rd.reprio), $sampled(e_rd.reprio));

    // --------------------
    // Stimulus helpers, called and returning on a falling edge
    task automatic issue(micro_op_t op, logic [31:0] yw);
        uop = op;
        y   = yw;
        @(negedge clk);
    endtask

    task automatic load_page(logic [9:0] p);
        micro_op_t op;
        op = '0;
        op.ydst = YD_PHYSPG;
        issue(op, {12'd0, p, 10'd0});
    endtask

    task automatic wait_fill(int limit);
        int n;
        n = 0;
        uop = '0;
        uop.cond_sel = C_FULMEM;            // True once the fill is idle
        y = '0;
        do begin
            @(negedge clk);
            n++;
            if (n > limit)
                fail_timeout("reprioritize fill never finished");
        end while (o_cond !== 1'b1);
    endtask

    task automatic wait_ready(int limit);
        int n;
        n = 0;
        uop = '0;
        uop.cond_sel = C_ARBRDY;
        y = '0;
        while (o_arb_rdy !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > limit)
                fail_timeout("bus cycle never reported ready");
        end
    endtask

    initial begin : stimulus
        micro_op_t   op;
        logic [31:0] r;
        logic [9:0]  pg;
        int          start;
        uop = '0;
        uop.cond_sel = C_FULMEM;            // Inverted FULMEM reads 0 after reset
        uop.icc = 1'b1;
        y = '0;
        reset = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        issue(uop, '0);

        // Mode register loads, triggers and condition select
        for (int i = 0; i < 80; i++) begin
            r = next_rand();
            op = '0;
            if (i % 8 == 0)
                op.ydst = YD_CNT;
            else
                op.ffcnt = trig_list[next_rand() % 19];
            op.cond_sel = cond_e'(r[9:5]);
            op.icc = r[10];
            op.ise = (r[12:11] == 2'b00);
            if (r[14:13] == 2'b00)
                op.ddev = DV_CLRCB;
            issue(op, next_rand());
        end
        for (int c = 0; c < 64; c++) begin
            op = '0;
            op.cond_sel = cond_e'(c[4:0]);
            op.icc = c[5];
            issue(op, '0);
        end

        // Full fill from page 0 sets every reprio bit
        op = '0;
        op.ffcnt = STRTLD;
        issue(op, '0);
        wait_fill(1100);

        // Page map and access bits at random pages
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            pg = r[19:10];
            op = '0;
            op.ydst = YD_ADRREG;
            issue(op, r);
            op = '0;
            op.ydst = YD_PHYSPG;
            op.ydev = YV_PSMEM;
            op.wry = 1'b1;
            issue(op, (next_rand() & 32'hFFF0_03FF) | {12'd0, pg, 10'd0});
            op = '0;
            op.ddev = DV_ACCESS;
            op.wrd = 1'b1;
            issue(op, next_rand());
            op.ddev = DV_REPRIO;
            issue(op, next_rand());
            op = '0;
            issue(op, '0);
            issue(op, '0);
        end

        // Partial fill, with a command write to reprio dropped midway
        start = 700 + int'(next_rand() % 200);
        load_page(10'(start + 3));
        op = '0;
        op.ddev = DV_REPRIO;
        op.wrd = 1'b1;
        issue(op, '0);
        load_page(10'(start));
        op = '0;
        op.ffcnt = STRTLD;
        op.cond_sel = C_FULMEM;
        issue(op, '0);
        op = '0;
        op.cond_sel = C_FULMEM;
        repeat (5) issue(op, '0);
        op.ddev = DV_REPRIO;
        op.wrd = 1'b1;
        issue(op, '0);
        wait_fill(1024 - start);
        for (int i = 0; i < 8; i++) begin
            load_page((i < 4) ? 10'(start + i) : 10'(1023 - i));
            op = '0;
            issue(op, '0);
            issue(op, '0);
        end

        // Bus reads and writes, plus an opcode while a cycle is pending
        for (int i = 0; i < 12; i++) begin
            op = '0;
            op.ydst = YD_ADRREG;
            issue(op, next_rand());
            r = next_rand();
            op = '0;
            op.cond_sel = C_ARBRDY;
            if (i % 2 == 0) begin
                op.arbi = r[0] ? ARB_WRITE : ARB_READ;
                issue(op, next_rand());
            end else begin
                op.ydst = YD_ARBOPC;
                issue(op, {r[31:4], r[0] ? 4'd2 : 4'd1});
            end
            op = '0;
            op.cond_sel = C_ARBRDY;
            op.arbi = ARB_WRITE;            // Ignored, cycle in flight
            issue(op, next_rand());
            wait_ready(40);
        end
        op = '0;
        repeat (4) issue(op, '0);
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- src.f
design/besm_pkg.sv
design/mode_cond_unit.sv
design/page_table.sv
design/ext_bus_arbiter.sv
design/besm_ctrl_top.sv
tb/tb_top.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status follows the simulation
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f src.f -o tb_sim \
    && ./obj_dir/tb_sim \
    || { echo "Simulation run did not complete cleanly"; exit 1; }
